/* dv/ibuffer_assertions.sv */
`timescale 1ns/1ps

module ibuffer_assertions (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    enq_valid,
    input logic                    enq_ready,
    input ibuffer_pkg::ibuf_idx_t  enq_ptr,
    input ibuffer_pkg::ibuf_idx_t  deq_ptr,
    input logic                    not_empty,
    input logic                    miss_fill_valid,
    input logic                    hit_fill_valid,
    input logic                    restart_valid,
    input logic                    instr_yield_valid,
    input logic                    instr_yield_ready,
    input ibuffer_pkg::ibuf_info_t instr_yield_info,
    input ibuffer_pkg::fetch16B_t  instr_yield_fetch16B
);
    import ibuffer_pkg::*;

    int fail_count = 0;

    // --------------------------------------------------
    // protocol properties

    // full when the pointers meet with entries present
    a_no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
        (enq_valid && enq_ready) |-> !(enq_ptr == deq_ptr && not_empty))
        else begin
            fail_count++;
            $error("enqueue fired while the buffer was full");
        end

    a_one_writer: assert property (@(posedge CLK) disable iff (!nRST)
        !(miss_fill_valid && hit_fill_valid))
        else begin
            fail_count++;
            $error("miss fill and hit fill both requested the write port");
        end

    a_restart_clears: assert property (@(posedge CLK) disable iff (!nRST)
        restart_valid |=> !instr_yield_valid)
        else begin
            fail_count++;
            $error("yield still valid in the cycle after restart");
        end

    // held under back-pressure unless flushed
    a_yield_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (instr_yield_valid && !instr_yield_ready && !restart_valid) |=>
        (instr_yield_valid && $stable(instr_yield_info) && $stable(instr_yield_fetch16B)))
        else begin
            fail_count++;
            $error("yield outputs changed while stalled");
        end

endmodule

bind ibuffer_top ibuffer_assertions chk (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .enq_valid            (enq_valid),
    .enq_ready            (enq_ready),
    .enq_ptr              (queue_ctrl.enq_ptr),
    .deq_ptr              (queue_ctrl.deq_ptr),
    .not_empty            (queue_ctrl.not_empty),
    .miss_fill_valid      (miss_fill_valid),
    .hit_fill_valid       (hit_fill_valid),
    .restart_valid        (restart_valid),
    .instr_yield_valid    (instr_yield_valid),
    .instr_yield_ready    (instr_yield_ready),
    .instr_yield_info     (instr_yield_info),
    .instr_yield_fetch16B (instr_yield_fetch16B)
);

/* dv/tb_ibuffer.sv */
`timescale 1ns/1ps
`include "ibuffer_consts.svh"

module tb_ibuffer;
    import ibuffer_pkg::*;

    // roughly 200 cycles of tests plus reset, with margin
    localparam int MAX_CYCLES = 600;

    logic       CLK = 1'b0;
    logic       nRST;
    logic       enq_valid;
    ibuf_info_t enq_info;
    logic       enq_fetch_hit_valid;
    fetch16B_t  enq_fetch_hit_fetch16B;
    logic       enq_ready;
    fmid_t      enq_fmid;
    logic       fetch_miss_return_valid;
    fmid_t      fetch_miss_return_fmid;
    fetch16B_t  fetch_miss_return_fetch16B;
    logic       instr_yield_ready;
    logic       instr_yield_valid;
    ibuf_info_t instr_yield_info;
    fetch16B_t  instr_yield_fetch16B;
    logic       restart_valid;

    // reference queue, in enqueue order
    ibuf_info_t exp_info [$];
    fetch16B_t  exp_data [$];
    fmid_t      exp_fmid [$];
    bit         exp_wait [$];
    bit [`FMID_COUNT-1:0] free_ids;
    logic [31:0] seed = 32'h1375;
    int          cycles = 0;

    ibuffer_top UUT (.*);

    always #4 CLK = ~CLK;

    task automatic abort_run;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next;
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // bound checker failures end the run at once
    always @(negedge CLK) begin
        if (UUT.chk.fail_count != 0) begin
            $display("a bound assertion failed, see the error above");
            abort_run();
        end
    end

    // --------------------------------------------------
    // yield checker, samples mid-cycle

    always @(negedge CLK) begin
        if (nRST && instr_yield_valid && instr_yield_ready) begin
            assert (exp_info.size() != 0) else begin
                $display("block yielded while none was expected");
                abort_run();
            end
            assert (!exp_wait[0]) else begin
                $display("block yielded before its miss data returned");
                abort_run();
            end
            assert (instr_yield_info == exp_info[0]) else begin
                $display("MISMATCH instr_yield_info exp=%h got=%h",
                    exp_info[0], instr_yield_info);
                abort_run();
            end
            assert (instr_yield_fetch16B == exp_data[0]) else begin
                $display("MISMATCH instr_yield_fetch16B exp=%h got=%h",
                    exp_data[0], instr_yield_fetch16B);
                abort_run();
            end
            void'(exp_info.pop_front());
            void'(exp_data.pop_front());
            void'(exp_fmid.pop_front());
            void'(exp_wait.pop_front());
        end
    end

    // --------------------------------------------------
    // driver tasks

    // one enqueue attempt in one cycle
    task automatic present_enq(input bit hit, output bit fired);
        logic [63:0] pc_bits;
        fmid_t       want;
        bit          found;
        pc_bits = {lcg_next(), lcg_next()};
        enq_valid = 1'b1;
        enq_fetch_hit_valid = hit;
        enq_info.src_pc = pc_bits[`PC_BLOCK_W-1:0];
        enq_info.page_fault = pc_bits[40];
        enq_info.access_fault = pc_bits[45];
        enq_fetch_hit_fetch16B = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        @(negedge CLK);
        fired = enq_ready;
        if (fired) begin
            // lowest free id is the one handed out
            want = '0;
            found = 1'b0;
            for (int i = 0; i < `FMID_COUNT; i++) begin
                if (free_ids[i] && !found) begin
                    want = fmid_t'(i);
                    found = 1'b1;
                end
            end
            if (!hit) begin
                assert (enq_fmid == want) else begin
                    $display("MISMATCH enq_fmid exp=%h got=%h", want, enq_fmid);
                    abort_run();
                end
                free_ids[want] = 1'b0;
            end
            exp_info.push_back(enq_info);
            exp_data.push_back(enq_fetch_hit_fetch16B);
            exp_fmid.push_back(want);
            exp_wait.push_back(!hit);
        end
        @(posedge CLK);
        #1;
        enq_valid = 1'b0;
    endtask

    task automatic enq_block(input bit hit);
        bit fired;
        fired = 1'b0;
        while (!fired) begin
            present_enq(hit, fired);
        end
    endtask

    // model side of a miss return, any return frees its id
    function automatic void apply_return(input fmid_t id, input fetch16B_t data);
        for (int i = 0; i < exp_info.size(); i++) begin
            if (exp_wait[i] && exp_fmid[i] == id) begin
                exp_data[i] = data;
                exp_wait[i] = 1'b0;
            end
        end
        free_ids[id] = 1'b1;
    endfunction

    task automatic miss_return(input fmid_t id);
        fetch_miss_return_valid = 1'b1;
        fetch_miss_return_fmid = id;
        fetch_miss_return_fetch16B = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        @(negedge CLK);
        apply_return(id, fetch_miss_return_fetch16B);
        @(posedge CLK);
        #1;
        fetch_miss_return_valid = 1'b0;
    endtask

    task automatic wait_drained;
        while (exp_info.size() != 0) begin
            @(posedge CLK);
            #1;
        end
    endtask

    // --------------------------------------------------
    // directed tests

    task automatic hit_ordering;
        instr_yield_ready = 1'b1;
        enq_block(1'b1);
        @(negedge CLK);
        assert (!instr_yield_valid) else begin
            $display("first hit yielded one cycle after enqueue");
            abort_run();
        end
        @(negedge CLK);
        assert (instr_yield_valid) else begin
            $display("first hit did not yield two cycles after enqueue");
            abort_run();
        end
        @(posedge CLK);
        #1;
        repeat (9) enq_block(1'b1);
        wait_drained();
    endtask

    task automatic miss_fill_out_of_order;
        repeat (3) enq_block(1'b0);
        repeat (4) begin
            @(negedge CLK);
            assert (!instr_yield_valid) else begin
                $display("block yielded while every miss was outstanding");
                abort_run();
            end
        end
        @(posedge CLK);
        #1;
        miss_return(2'd2);
        miss_return(2'd0);
        miss_return(2'd1);
        wait_drained();
    endtask

    task automatic full_and_fmid_exhaustion;
        bit fired;
        int count;
        instr_yield_ready = 1'b0;
        count = 0;
        fired = 1'b1;
        while (fired && count < 20) begin
            present_enq(1'b1, fired);
            if (fired) begin
                count++;
            end
        end
        assert (count == `IBUF_ENTRIES + 1) else begin
            $display("enq_ready fell after %0d blocks instead of %0d", count, `IBUF_ENTRIES + 1);
            abort_run();
        end
        instr_yield_ready = 1'b1;
        wait_drained();
        repeat (`FMID_COUNT) enq_block(1'b0);
        present_enq(1'b0, fired);
        assert (!fired) else begin
            $display("miss accepted with no free fetch-miss id");
            abort_run();
        end
        present_enq(1'b1, fired);
        assert (fired) else begin
            $display("hit refused while fetch-miss ids were exhausted");
            abort_run();
        end
        for (int i = 0; i < `FMID_COUNT; i++) begin
            miss_return(fmid_t'(i));
        end
        wait_drained();
    endtask

    task automatic write_port_collision;
        bit fired;
        enq_block(1'b0);
        fetch_miss_return_valid = 1'b1;
        fetch_miss_return_fmid = 2'd0;
        fetch_miss_return_fetch16B = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        present_enq(1'b1, fired);
        assert (!fired) else begin
            $display("hit accepted in the same cycle as a miss fill");
            abort_run();
        end
        apply_return(2'd0, fetch_miss_return_fetch16B);
        fetch_miss_return_valid = 1'b0;
        enq_block(1'b1);
        wait_drained();
    endtask

    // every fmid taken before the flush, so enq_ready is low for a miss
    task automatic restart_flush;
        instr_yield_ready = 1'b0;
        enq_block(1'b1);
        enq_block(1'b0);
        enq_block(1'b1);
        repeat (`FMID_COUNT - 1) enq_block(1'b0);
        restart_valid = 1'b1;
        @(posedge CLK);
        #1;
        restart_valid = 1'b0;
        exp_info.delete();
        exp_data.delete();
        exp_fmid.delete();
        exp_wait.delete();
        free_ids = '1;
        @(negedge CLK);
        assert (enq_ready && !instr_yield_valid) else begin
            $display("buffer not empty and ready after restart");
            abort_run();
        end
        @(posedge CLK);
        #1;
        instr_yield_ready = 1'b1;
        repeat (5) @(posedge CLK);
        #1;
        enq_block(1'b0);
        miss_return(2'd0);
        enq_block(1'b1);
        wait_drained();
    endtask

    initial begin
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_info = '0;
        enq_fetch_hit_valid = 1'b0;
        enq_fetch_hit_fetch16B = '0;
        fetch_miss_return_valid = 1'b0;
        fetch_miss_return_fmid = '0;
        fetch_miss_return_fetch16B = '0;
        instr_yield_ready = 1'b0;
        restart_valid = 1'b0;
        free_ids = '1;
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;
        hit_ordering();
        miss_fill_out_of_order();
        full_and_fmid_exhaustion();
        write_port_collision();
        restart_flush();
        if (UUT.chk.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            abort_run();
        end
    end

endmodule

/* filelist.f */
+incdir+source
source/ibuffer_pkg.sv
source/ibuffer_entry_if.sv
source/ibuffer_distram.sv
source/ibuffer_queue_ctrl.sv
source/fetch_miss_tracker.sv
source/instr_fill_port.sv
source/yield_stage.sv
source/ibuffer_top.sv
dv/ibuffer_assertions.sv
dv/tb_ibuffer.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
    --top-module tb_ibuffer -o sim_ibuffer && ./obj_dir/sim_ibuffer > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0

/* source/fetch_miss_tracker.sv */
`timescale 1ns/1ps
`include "ibuffer_consts.svh"

module fetch_miss_tracker (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 restart_valid,
    ibuffer_entry_if.tracker     entry_if,
    input  logic                 enq_fetch_hit_valid,
    input  logic                 fetch_miss_return_valid,
    input  ibuffer_pkg::fmid_t   fetch_miss_return_fmid,
    output ibuffer_pkg::fmid_t   enq_fmid,
    output logic                 miss_fill_valid,
    output ibuffer_pkg::ibuf_idx_t miss_fill_idx,
    output logic                 hit_fill_valid
);
    import ibuffer_pkg::*;

    logic [`IBUF_ENTRIES-1:0] waiting;
    fmid_t                    fmid_by_entry [`IBUF_ENTRIES];
    logic [`FMID_COUNT-1:0]   fmid_free;
    logic [`IBUF_ENTRIES-1:0] fill_match;
    logic                     miss_enq;

    // --------------------------------------------------
    // fmid offer and return matching

    always_comb begin
        enq_fmid = '0;
        for (int i = `FMID_COUNT - 1; i >= 0; i--) begin
            if (fmid_free[i]) begin
                enq_fmid = fmid_t'(i);
            end
        end
        miss_fill_idx = '0;
        for (int i = `IBUF_ENTRIES - 1; i >= 0; i--) begin
            fill_match[i] = fetch_miss_return_valid & waiting[i]
                & (fmid_by_entry[i] == fetch_miss_return_fmid);
            if (fill_match[i]) begin
                miss_fill_idx = ibuf_idx_t'(i);
            end
        end
    end

    assign miss_fill_valid = |fill_match;

    // hit needs the write port, miss needs an fmid
    assign entry_if.accept_ok = enq_fetch_hit_valid ? ~miss_fill_valid : |fmid_free;
    assign entry_if.head_waiting = waiting[entry_if.deq_idx];

    assign hit_fill_valid = entry_if.enq_fire & enq_fetch_hit_valid;
    assign miss_enq       = entry_if.enq_fire & ~enq_fetch_hit_valid;

    // --------------------------------------------------
    // state

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            waiting   <= '0;
            fmid_free <= '1;
        end else if (restart_valid) begin
            waiting   <= '0;
            fmid_free <= '1;
        end else begin
            if (entry_if.enq_fire) begin
                waiting[entry_if.enq_idx] <= ~enq_fetch_hit_valid;
            end
            if (miss_fill_valid) begin
                waiting[miss_fill_idx] <= 1'b0;
            end
            // any return frees its id, matched or not
            if (fetch_miss_return_valid) begin
                fmid_free[fetch_miss_return_fmid] <= 1'b1;
            end
            if (miss_enq) begin
                fmid_free[enq_fmid] <= 1'b0;
            end
        end
    end

    // fmid held by each waiting entry
    always_ff @(posedge CLK) begin
        if (miss_enq) begin
            fmid_by_entry[entry_if.enq_idx] <= enq_fmid;
        end
    end

endmodule

/* source/ibuffer_consts.svh */
`ifndef IBUFFER_CONSTS_SVH
`define IBUFFER_CONSTS_SVH

// buffer depth, kept a power of two so pointers wrap for free
`define IBUF_ENTRIES 8
`define IBUF_IDX_W   3

// outstanding fetch misses
`define FMID_COUNT   4
`define FMID_W       2

// fetch block geometry
`define FETCH_LANES  8
`define PC_BLOCK_W   35

`endif

/* source/ibuffer_distram.sv */
`timescale 1ns/1ps
`include "ibuffer_consts.svh"

module ibuffer_distram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `IBUF_ENTRIES
) (
    input  logic                   CLK,
    input  logic                   wen,
    input  ibuffer_pkg::ibuf_idx_t windex,
    input  entry_t                 wdata,
    input  ibuffer_pkg::ibuf_idx_t rindex,
    output entry_t                 rdata
);
    import ibuffer_pkg::*;

    entry_t mem [DEPTH];

    // write at the edge, no reset on the array
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

    // async read
    assign rdata = mem[rindex];

endmodule

/* source/ibuffer_entry_if.sv */
`timescale 1ns/1ps

interface ibuffer_entry_if;

    // queue side
    logic                  enq_fire;
    ibuffer_pkg::ibuf_idx_t enq_idx;
    ibuffer_pkg::ibuf_idx_t deq_idx;

    // tracker side
    logic                  accept_ok;
    logic                  head_waiting;

    modport queue (output enq_fire, enq_idx, deq_idx, input accept_ok, head_waiting);

    modport tracker (input enq_fire, enq_idx, deq_idx, output accept_ok, head_waiting);

endinterface

/* source/ibuffer_pkg.sv */
`include "ibuffer_consts.svh"

package ibuffer_pkg;

    // --------------------------------------------------
    // index and id types

    typedef logic [`IBUF_IDX_W-1:0] ibuf_idx_t;
    typedef logic [`FMID_W-1:0]     fmid_t;

    // --------------------------------------------------
    // payload types

    // one 16-byte block, lane 0 in the low bits
    typedef logic [`FETCH_LANES-1:0][15:0] fetch16B_t;

    typedef struct packed {
        logic [`PC_BLOCK_W-1:0] src_pc;
        logic                   page_fault;
        logic                   access_fault;
    } ibuf_info_t;

endpackage

/* source/ibuffer_queue_ctrl.sv */
`timescale 1ns/1ps
`include "ibuffer_consts.svh"

module ibuffer_queue_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    restart_valid,
    input  logic                    enq_valid,
    input  ibuffer_pkg::ibuf_info_t enq_info,
    output logic                    enq_ready,
    ibuffer_entry_if.queue          entry_if,
    output logic                    deq_valid,
    input  logic                    deq_ready,
    output ibuffer_pkg::ibuf_info_t deq_info
);
    import ibuffer_pkg::*;

    ibuf_idx_t enq_ptr;
    ibuf_idx_t deq_ptr;
    logic      not_full;
    logic      not_empty;
    logic      enq_fire;
    logic      deq_fire;

    // --------------------------------------------------
    // handshakes

    assign enq_ready = not_full & entry_if.accept_ok;
    assign enq_fire  = enq_valid & enq_ready;
    // head blocked while its miss data is still out
    assign deq_valid = not_empty & ~entry_if.head_waiting;
    assign deq_fire  = deq_valid & deq_ready;

    assign entry_if.enq_fire = enq_fire;
    assign entry_if.enq_idx  = enq_ptr;
    assign entry_if.deq_idx  = deq_ptr;

    // --------------------------------------------------
    // pointers and flags

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            enq_ptr   <= '0;
            deq_ptr   <= '0;
            not_full  <= 1'b1;
            not_empty <= 1'b0;
        end else if (restart_valid) begin
            enq_ptr   <= '0;
            deq_ptr   <= '0;
            not_full  <= 1'b1;
            not_empty <= 1'b0;
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr + ibuf_idx_t'(1);
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr + ibuf_idx_t'(1);
            end
            // flags only move when exactly one side fires
            if (enq_fire & ~deq_fire) begin
                not_full  <= (enq_ptr + ibuf_idx_t'(1)) != deq_ptr;
                not_empty <= 1'b1;
            end
            if (deq_fire & ~enq_fire) begin
                not_full  <= 1'b1;
                not_empty <= (deq_ptr + ibuf_idx_t'(1)) != enq_ptr;
            end
        end
    end

    ibuffer_distram #(
        .entry_t (ibuf_info_t),
        .DEPTH   (`IBUF_ENTRIES)
    ) info_store (
        .CLK    (CLK),
        .wen    (enq_fire),
        .windex (enq_ptr),
        .wdata  (enq_info),
        .rindex (deq_ptr),
        .rdata  (deq_info)
    );

endmodule

/* source/ibuffer_top.sv */
`timescale 1ns/1ps

module ibuffer_top (
    input  logic                    CLK,
    input  logic                    nRST,

    // enqueue
    input  logic                    enq_valid,
    input  ibuffer_pkg::ibuf_info_t enq_info,
    input  logic                    enq_fetch_hit_valid,
    input  ibuffer_pkg::fetch16B_t  enq_fetch_hit_fetch16B,
    output logic                    enq_ready,
    output ibuffer_pkg::fmid_t      enq_fmid,

    // miss return
    input  logic                    fetch_miss_return_valid,
    input  ibuffer_pkg::fmid_t      fetch_miss_return_fmid,
    input  ibuffer_pkg::fetch16B_t  fetch_miss_return_fetch16B,

    // yield
    input  logic                    instr_yield_ready,
    output logic                    instr_yield_valid,
    output ibuffer_pkg::ibuf_info_t instr_yield_info,
    output ibuffer_pkg::fetch16B_t  instr_yield_fetch16B,

    // flush
    input  logic                    restart_valid
);
    import ibuffer_pkg::*;

    // --------------------------------------------------
    // internal wires

    ibuffer_entry_if entry_if ();

    logic       miss_fill_valid;
    ibuf_idx_t  miss_fill_idx;
    logic       hit_fill_valid;
    logic       deq_valid;
    logic       deq_ready;
    ibuf_info_t deq_info;
    fetch16B_t  deq_fetch16B;

    // --------------------------------------------------
    // instances

    ibuffer_queue_ctrl queue_ctrl (
        .CLK           (CLK),
        .nRST          (nRST),
        .restart_valid (restart_valid),
        .enq_valid     (enq_valid),
        .enq_info      (enq_info),
        .enq_ready     (enq_ready),
        .entry_if      (entry_if.queue),
        .deq_valid     (deq_valid),
        .deq_ready     (deq_ready),
        .deq_info      (deq_info)
    );

    fetch_miss_tracker miss_tracker (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .restart_valid           (restart_valid),
        .entry_if                (entry_if.tracker),
        .enq_fetch_hit_valid     (enq_fetch_hit_valid),
        .fetch_miss_return_valid (fetch_miss_return_valid),
        .fetch_miss_return_fmid  (fetch_miss_return_fmid),
        .enq_fmid                (enq_fmid),
        .miss_fill_valid         (miss_fill_valid),
        .miss_fill_idx           (miss_fill_idx),
        .hit_fill_valid          (hit_fill_valid)
    );

    // hit data lands at the enqueue slot
    instr_fill_port fill_port (
        .CLK             (CLK),
        .miss_fill_valid (miss_fill_valid),
        .miss_fill_idx   (miss_fill_idx),
        .miss_fill_data  (fetch_miss_return_fetch16B),
        .hit_fill_valid  (hit_fill_valid),
        .hit_fill_idx    (entry_if.enq_idx),
        .hit_fill_data   (enq_fetch_hit_fetch16B),
        .rindex          (entry_if.deq_idx),
        .rdata           (deq_fetch16B)
    );

    yield_stage yield_reg (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .restart_valid        (restart_valid),
        .deq_valid            (deq_valid),
        .deq_ready            (deq_ready),
        .deq_info             (deq_info),
        .deq_fetch16B         (deq_fetch16B),
        .instr_yield_ready    (instr_yield_ready),
        .instr_yield_valid    (instr_yield_valid),
        .instr_yield_info     (instr_yield_info),
        .instr_yield_fetch16B (instr_yield_fetch16B)
    );

endmodule

/* source/instr_fill_port.sv */
`timescale 1ns/1ps
`include "ibuffer_consts.svh"

module instr_fill_port (
    input  logic                   CLK,
    input  logic                   miss_fill_valid,
    input  ibuffer_pkg::ibuf_idx_t miss_fill_idx,
    input  ibuffer_pkg::fetch16B_t miss_fill_data,
    input  logic                   hit_fill_valid,
    input  ibuffer_pkg::ibuf_idx_t hit_fill_idx,
    input  ibuffer_pkg::fetch16B_t hit_fill_data,
    input  ibuffer_pkg::ibuf_idx_t rindex,
    output ibuffer_pkg::fetch16B_t rdata
);
    import ibuffer_pkg::*;

    logic      wen;
    ibuf_idx_t windex;
    fetch16B_t wdata;

    // fixed priority, miss fill wins the write port
    assign wen    = miss_fill_valid | hit_fill_valid;
    assign windex = miss_fill_valid ? miss_fill_idx : hit_fill_idx;
    assign wdata  = miss_fill_valid ? miss_fill_data : hit_fill_data;

    ibuffer_distram #(
        .entry_t (fetch16B_t),
        .DEPTH   (`IBUF_ENTRIES)
    ) instr_store (
        .CLK    (CLK),
        .wen    (wen),
        .windex (windex),
        .wdata  (wdata),
        .rindex (rindex),
        .rdata  (rdata)
    );

endmodule

/* source/yield_stage.sv */
`timescale 1ns/1ps

module yield_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    restart_valid,
    input  logic                    deq_valid,
    output logic                    deq_ready,
    input  ibuffer_pkg::ibuf_info_t deq_info,
    input  ibuffer_pkg::fetch16B_t  deq_fetch16B,
    input  logic                    instr_yield_ready,
    output logic                    instr_yield_valid,
    output ibuffer_pkg::ibuf_info_t instr_yield_info,
    output ibuffer_pkg::fetch16B_t  instr_yield_fetch16B
);
    import ibuffer_pkg::*;

    logic load;

    // take a new block when empty or when the current one leaves
    assign deq_ready = ~instr_yield_valid | instr_yield_ready;
    assign load      = deq_valid & deq_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            instr_yield_valid <= 1'b0;
        end else if (restart_valid) begin
            instr_yield_valid <= 1'b0;
        end else if (deq_ready) begin
            instr_yield_valid <= deq_valid;
        end
    end

    // payload held under back-pressure
    always_ff @(posedge CLK) begin
        if (load) begin
            instr_yield_info     <= deq_info;
            instr_yield_fetch16B <= deq_fetch16B;
        end
    end

endmodule
